/* tinkerCfgPkg.sv */
package tinkerCfgPkg;

    // Machine widths
    localparam int wordBits = 64;
    localparam int instrBits = 32;

    // Register file shape
    localparam int regCount = 32;
    localparam int regIndexBits = 5;
    localparam int stackReg = 31;

    // Default memory is 512 KiB
    localparam int defaultMemAddrBits = 19;

    // First fetch address after reset
    localparam logic [wordBits-1:0] resetPc = 64'h2000;

endpackage

/* tinkerIsaPkg.sv */
package tinkerIsaPkg;

    localparam int opcodeBits = 5;
    localparam int literalBits = 12;

    typedef logic [opcodeBits-1:0] opcodeT;

    // Field positions, lsb of each field in the instruction word
    localparam int opcodeLsb = 27;
    localparam int rdLsb = 22;
    localparam int rsLsb = 17;
    localparam int rtLsb = 12;
    localparam int literalLsb = 0;

    // Logic and shifts
    localparam opcodeT opAnd = 5'h00;
    localparam opcodeT opOr = 5'h01;
    localparam opcodeT opXor = 5'h02;
    localparam opcodeT opNot = 5'h03;
    localparam opcodeT opShr = 5'h04;
    localparam opcodeT opShl = 5'h06;

    // Control flow
    localparam opcodeT opJmp = 5'h08;
    localparam opcodeT opBr = 5'h0A;
    localparam opcodeT opBrnz = 5'h0B;
    localparam opcodeT opCall = 5'h0C;
    localparam opcodeT opRet = 5'h0D;
    localparam opcodeT opBrgt = 5'h0E;
    localparam opcodeT opHalt = 5'h0F;

    // Memory and data movement
    localparam opcodeT opLd = 5'h10;
    localparam opcodeT opMerge = 5'h12;
    localparam opcodeT opSt = 5'h13;

    // Integer arithmetic
    localparam opcodeT opAdd = 5'h18;
    localparam opcodeT opAddi = 5'h19;
    localparam opcodeT opSub = 5'h1A;
    localparam opcodeT opSubi = 5'h1B;
    localparam opcodeT opMul = 5'h1C;

    typedef enum logic [2:0] {
        stFetch,
        stDecode,
        stExecute,
        stMemory,
        stWriteback,
        stHalted
    } seqStateT;

endpackage

/* fetchUnit.sv */
module fetchUnit (
    input  logic clk,
    input  logic reset,
    input  logic pcUpdate,
    input  logic pcFromMemory,
    input  logic [tinkerCfgPkg::wordBits-1:0] nextPc,
    input  logic [tinkerCfgPkg::wordBits-1:0] readData,
    output logic [tinkerCfgPkg::wordBits-1:0] pc
);
    import tinkerCfgPkg::*;

    logic [wordBits-1:0] pcTarget;

    // Return takes its target from the stack slot in memory
    assign pcTarget = pcFromMemory ? readData : nextPc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= resetPc;
        end else if (pcUpdate) begin
            pc <= pcTarget;
        end
    end

endmodule

/* tinkerMemory.sv */
module tinkerMemory #(
    parameter int memAddrBits = tinkerCfgPkg::defaultMemAddrBits
) (
    input  logic clk,
    input  logic [tinkerCfgPkg::wordBits-1:0] pc,
    input  logic [tinkerCfgPkg::wordBits-1:0] dataAddress,
    input  logic [tinkerCfgPkg::wordBits-1:0] storeData,
    input  logic memWriteEnable,
    input  logic loadStrobe,
    input  logic [tinkerCfgPkg::wordBits-1:0] loadAddress,
    input  logic [tinkerCfgPkg::instrBits-1:0] loadWord,
    output logic [tinkerCfgPkg::instrBits-1:0] instruction,
    output logic [tinkerCfgPkg::wordBits-1:0] readData
);
    import tinkerCfgPkg::*;

    localparam int memBytes = 1 << memAddrBits;
    localparam int instrBytes = instrBits / 8;
    localparam int wordBytes = wordBits / 8;

    logic [7:0] storage [memBytes];
    logic [memAddrBits-1:0] pcIndex;
    logic [memAddrBits-1:0] dataIndex;
    logic [memAddrBits-1:0] loadIndex;

    // Addresses wrap at the memory size
    assign pcIndex = pc[memAddrBits-1:0];
    assign dataIndex = dataAddress[memAddrBits-1:0];
    assign loadIndex = loadAddress[memAddrBits-1:0];

    // Little-endian assembly, lowest address in the low byte
    always_comb begin
        for (int i = 0; i < instrBytes; i++) begin
            instruction[8*i +: 8] = storage[pcIndex + memAddrBits'(i)];
        end
    end

    always_comb begin
        for (int i = 0; i < wordBytes; i++) begin
            readData[8*i +: 8] = storage[dataIndex + memAddrBits'(i)];
        end
    end

    // Program load only happens while the core is held in reset
    always_ff @(posedge clk) begin
        if (loadStrobe) begin
            for (int i = 0; i < instrBytes; i++) begin
                storage[loadIndex + memAddrBits'(i)] <= loadWord[8*i +: 8];
            end
        end else if (memWriteEnable) begin
            for (int i = 0; i < wordBytes; i++) begin
                storage[dataIndex + memAddrBits'(i)] <= storeData[8*i +: 8];
            end
        end
    end

endmodule

/* sequencer.sv */
module sequencer (
    input  logic clk,
    input  logic reset,
    input  logic [tinkerCfgPkg::instrBits-1:0] instruction,
    output tinkerIsaPkg::opcodeT opcode,
    output logic [tinkerCfgPkg::regIndexBits-1:0] rdIndex,
    output logic [tinkerCfgPkg::regIndexBits-1:0] rsIndex,
    output logic [tinkerCfgPkg::regIndexBits-1:0] rtIndex,
    output logic [tinkerIsaPkg::literalBits-1:0] literal,
    output logic useLiteral,
    output logic pcUpdate,
    output logic pcFromMemory,
    output logic regWriteEnable,
    output logic writeFromMemory,
    output logic memWriteEnable,
    output logic hlt
);
    import tinkerCfgPkg::*;
    import tinkerIsaPkg::*;

    seqStateT state;
    seqStateT stateNext;
    opcodeT decodedOp;
    logic immForm;
    logic writesReg;
    logic usesMemory;

    assign decodedOp = instruction[opcodeLsb +: opcodeBits];
    // addi, subi and merge read rd as their first source
    assign immForm = decodedOp == opAddi || decodedOp == opSubi || decodedOp == opMerge;

    always_comb begin
        case (opcode)
            opAnd, opOr, opXor, opNot, opShr, opShl,
            opMerge, opAdd, opAddi, opSub, opSubi, opMul, opLd: writesReg = 1'b1;
            default: writesReg = 1'b0;
        endcase
    end

    assign usesMemory = opcode == opLd || opcode == opSt || opcode == opCall || opcode == opRet;

    always_comb begin
        case (state)
            stFetch: stateNext = stDecode;
            stDecode: stateNext = stExecute;
            stExecute: begin
                if (opcode == opHalt) begin
                    stateNext = stHalted;
                end else if (usesMemory) begin
                    stateNext = stMemory;
                end else if (writesReg) begin
                    stateNext = stWriteback;
                end else begin
                    stateNext = stFetch;
                end
            end
            stMemory: stateNext = writesReg ? stWriteback : stFetch;
            stWriteback: stateNext = stFetch;
            stHalted: stateNext = stHalted;
            default: stateNext = stFetch;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= stFetch;
            opcode <= '0;
            useLiteral <= 1'b0;
        end else begin
            state <= stateNext;
            if (state == stDecode) begin
                opcode <= decodedOp;
                useLiteral <= immForm || decodedOp == opLd || decodedOp == opSt;
            end
        end
    end

    // Register fields are held from decode to the end of the instruction
    always_ff @(posedge clk) begin
        if (state == stDecode) begin
            rdIndex <= instruction[rdLsb +: regIndexBits];
            rsIndex <= immForm ? instruction[rdLsb +: regIndexBits]
                               : instruction[rsLsb +: regIndexBits];
            rtIndex <= instruction[rtLsb +: regIndexBits];
            literal <= instruction[literalLsb +: literalBits];
        end
    end

    // Last state of an instruction is the one that returns to fetch
    assign pcUpdate = stateNext == stFetch;
    assign pcFromMemory = state == stMemory && opcode == opRet;
    assign regWriteEnable = state == stWriteback;
    assign writeFromMemory = state == stWriteback && opcode == opLd;
    assign memWriteEnable = state == stMemory && (opcode == opSt || opcode == opCall);
    assign hlt = state == stHalted;

endmodule

/* registerFile.sv */
module registerFile #(
    parameter int memAddrBits = tinkerCfgPkg::defaultMemAddrBits
) (
    input  logic clk,
    input  logic reset,
    input  logic [tinkerCfgPkg::regIndexBits-1:0] rsIndex,
    input  logic [tinkerCfgPkg::regIndexBits-1:0] rtIndex,
    input  logic [tinkerCfgPkg::regIndexBits-1:0] rdIndex,
    input  logic regWriteEnable,
    input  logic writeFromMemory,
    input  logic [tinkerCfgPkg::wordBits-1:0] result,
    input  logic [tinkerCfgPkg::wordBits-1:0] readData,
    output logic [tinkerCfgPkg::wordBits-1:0] rsValue,
    output logic [tinkerCfgPkg::wordBits-1:0] rtValue,
    output logic [tinkerCfgPkg::wordBits-1:0] rdValue,
    output logic [tinkerCfgPkg::wordBits-1:0] stackValue
);
    import tinkerCfgPkg::*;

    // Stack starts one past the top of memory
    localparam logic [wordBits-1:0] stackTop = wordBits'(1) << memAddrBits;

    logic [wordBits-1:0] regs [regCount];
    logic [wordBits-1:0] writeData;

    assign writeData = writeFromMemory ? readData : result;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= (i == stackReg) ? stackTop : '0;
            end
        end else if (regWriteEnable) begin
            regs[rdIndex] <= writeData;
        end
    end

    assign rsValue = regs[rsIndex];
    assign rtValue = regs[rtIndex];
    assign rdValue = regs[rdIndex];
    assign stackValue = regs[stackReg];

endmodule

/* executeUnit.sv */
module executeUnit (
    input  tinkerIsaPkg::opcodeT opcode,
    input  logic useLiteral,
    input  logic [tinkerCfgPkg::wordBits-1:0] rsValue,
    input  logic [tinkerCfgPkg::wordBits-1:0] rtValue,
    input  logic [tinkerCfgPkg::wordBits-1:0] rdValue,
    input  logic [tinkerCfgPkg::wordBits-1:0] stackValue,
    input  logic [tinkerIsaPkg::literalBits-1:0] literal,
    input  logic [tinkerCfgPkg::wordBits-1:0] pc,
    output logic [tinkerCfgPkg::wordBits-1:0] result,
    output logic [tinkerCfgPkg::wordBits-1:0] dataAddress,
    output logic [tinkerCfgPkg::wordBits-1:0] storeData,
    output logic [tinkerCfgPkg::wordBits-1:0] nextPc
);
    import tinkerCfgPkg::*;
    import tinkerIsaPkg::*;

    logic [wordBits-1:0] operandB;
    logic [wordBits-1:0] pcPlus4;
    logic [wordBits-1:0] stackSlot;

    // Literal is zero-extended
    assign operandB = useLiteral ? {{(wordBits - literalBits){1'b0}}, literal} : rtValue;
    assign pcPlus4 = pc + wordBits'(4);
    assign stackSlot = stackValue - wordBits'(8);

    always_comb begin
        case (opcode)
            opAdd, opAddi: begin
                result = rsValue + operandB;
            end
            opSub, opSubi: begin
                result = rsValue - operandB;
            end
            opMul: begin
                result = rsValue * operandB;
            end
            opAnd: begin
                result = rsValue & operandB;
            end
            opOr: begin
                result = rsValue | operandB;
            end
            opXor: begin
                result = rsValue ^ operandB;
            end
            opNot: begin
                result = ~rsValue;
            end
            opShr: begin
                result = rsValue >> operandB;
            end
            opShl: begin
                result = rsValue << operandB;
            end
            opMerge: begin
                // Upper bits from rd, low bits from the literal
                result = {rsValue[wordBits-1:literalBits], operandB[literalBits-1:0]};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Call and return share the slot just below r31
    always_comb begin
        if (opcode == opCall || opcode == opRet) begin
            dataAddress = stackSlot;
        end else if (opcode == opSt) begin
            dataAddress = rdValue + operandB;
        end else begin
            dataAddress = rsValue + operandB;
        end
    end

    assign storeData = (opcode == opCall) ? pcPlus4 : rsValue;

    always_comb begin
        case (opcode)
            opJmp, opCall: begin
                nextPc = rdValue;
            end
            opBr: begin
                nextPc = pc + rtValue;
            end
            opBrnz: begin
                nextPc = (rsValue != '0) ? rdValue : pcPlus4;
            end
            opBrgt: begin
                // Unsigned compare
                nextPc = (rsValue > rtValue) ? rdValue : pcPlus4;
            end
            default: begin
                nextPc = pcPlus4;
            end
        endcase
    end

endmodule

/* tinkerCore.sv */
module tinkerCore #(
    parameter int memAddrBits = tinkerCfgPkg::defaultMemAddrBits
) (
    input  logic clk,
    input  logic reset,
    input  logic loadStrobe,
    input  logic [tinkerCfgPkg::wordBits-1:0] loadAddress,
    input  logic [tinkerCfgPkg::instrBits-1:0] loadWord,
    output logic hlt,
    output logic storeStrobe,
    output logic [tinkerCfgPkg::wordBits-1:0] storeAddress,
    output logic [tinkerCfgPkg::wordBits-1:0] storeData
);
    import tinkerCfgPkg::*;
    import tinkerIsaPkg::*;

    logic [wordBits-1:0] pc;
    logic [wordBits-1:0] nextPc;
    logic [wordBits-1:0] readData;
    logic [instrBits-1:0] instruction;

    opcodeT opcode;
    logic [regIndexBits-1:0] rdIndex;
    logic [regIndexBits-1:0] rsIndex;
    logic [regIndexBits-1:0] rtIndex;
    logic [literalBits-1:0] literal;
    logic useLiteral;
    logic pcUpdate;
    logic pcFromMemory;
    logic regWriteEnable;
    logic writeFromMemory;
    logic memWriteEnable;

    logic [wordBits-1:0] rsValue;
    logic [wordBits-1:0] rtValue;
    logic [wordBits-1:0] rdValue;
    logic [wordBits-1:0] stackValue;
    logic [wordBits-1:0] result;
    logic [wordBits-1:0] dataAddress;

    fetchUnit fetch (
        .clk(clk),
        .reset(reset),
        .pcUpdate(pcUpdate),
        .pcFromMemory(pcFromMemory),
        .nextPc(nextPc),
        .readData(readData),
        .pc(pc)
    );

    tinkerMemory #(
        .memAddrBits(memAddrBits)
    ) memory (
        .clk(clk),
        .pc(pc),
        .dataAddress(dataAddress),
        .storeData(storeData),
        .memWriteEnable(memWriteEnable),
        .loadStrobe(loadStrobe),
        .loadAddress(loadAddress),
        .loadWord(loadWord),
        .instruction(instruction),
        .readData(readData)
    );

    sequencer control (
        .clk(clk),
        .reset(reset),
        .instruction(instruction),
        .opcode(opcode),
        .rdIndex(rdIndex),
        .rsIndex(rsIndex),
        .rtIndex(rtIndex),
        .literal(literal),
        .useLiteral(useLiteral),
        .pcUpdate(pcUpdate),
        .pcFromMemory(pcFromMemory),
        .regWriteEnable(regWriteEnable),
        .writeFromMemory(writeFromMemory),
        .memWriteEnable(memWriteEnable),
        .hlt(hlt)
    );

    registerFile #(
        .memAddrBits(memAddrBits)
    ) regs (
        .clk(clk),
        .reset(reset),
        .rsIndex(rsIndex),
        .rtIndex(rtIndex),
        .rdIndex(rdIndex),
        .regWriteEnable(regWriteEnable),
        .writeFromMemory(writeFromMemory),
        .result(result),
        .readData(readData),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .rdValue(rdValue),
        .stackValue(stackValue)
    );

    executeUnit execute (
        .opcode(opcode),
        .useLiteral(useLiteral),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .rdValue(rdValue),
        .stackValue(stackValue),
        .literal(literal),
        .pc(pc),
        .result(result),
        .dataAddress(dataAddress),
        .storeData(storeData),
        .nextPc(nextPc)
    );

    // Every memory write is reported outside the core
    assign storeStrobe = memWriteEnable;
    assign storeAddress = dataAddress;

endmodule

/* tinkerCore_assert.sv */
module sequencerAssertions (
    input logic clk,
    input logic reset,
    input logic regWriteEnable,
    input logic memWriteEnable,
    input logic hlt,
    input tinkerIsaPkg::seqStateT state
);
    import tinkerIsaPkg::*;

    int failures = 0;

    writesExclusive: assert property (@(posedge clk) disable iff (reset)
        !(regWriteEnable && memWriteEnable))
        else begin
            failures++;
            $error("register and memory write enables high together");
        end

    // Only reset leaves the halted state
    hltSticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
        else begin
            failures++;
            $error("hlt fell without reset");
        end

    memWriteInMemoryState: assert property (@(posedge clk) disable iff (reset)
        memWriteEnable |-> state == stMemory)
        else begin
            failures++;
            $error("memory write enable outside the memory state");
        end

endmodule

bind sequencer sequencerAssertions checks (
    .clk(clk),
    .reset(reset),
    .regWriteEnable(regWriteEnable),
    .memWriteEnable(memWriteEnable),
    .hlt(hlt),
    .state(state)
);

/* tinkerCoreTb.sv */
module tinkerCoreTb;
    import tinkerCfgPkg::*;
    import tinkerIsaPkg::*;

    localparam int tbMemAddrBits = 16;
    localparam int resetCycles = 16;
    localparam int runLimit = 400;
    localparam int watchCycles = 8;
    localparam logic [63:0] programBase = 64'h2000;

    logic clk;
    logic reset;
    logic loadStrobe;
    logic [wordBits-1:0] loadAddress;
    logic [instrBits-1:0] loadWord;
    logic hlt;
    logic storeStrobe;
    logic [wordBits-1:0] storeAddress;
    logic [wordBits-1:0] storeData;

    logic [31:0] prog [$];
    logic [63:0] expAddr [$];
    logic [63:0] expData [$];
    int errors;
    int testsRun;
    int testsFailed;
    int assertFailures;

    tinkerCore #(
        .memAddrBits(tbMemAddrBits)
    ) uut (
        .clk(clk),
        .reset(reset),
        .loadStrobe(loadStrobe),
        .loadAddress(loadAddress),
        .loadWord(loadWord),
        .hlt(hlt),
        .storeStrobe(storeStrobe),
        .storeAddress(storeAddress),
        .storeData(storeData)
    );

    always #4 clk = ~clk;

    // Field order is opcode, rd, rs, rt, 12-bit literal
    function automatic logic [31:0] encode(opcodeT op, int rd, int rs, int rt, logic [11:0] lit);
        return {op, 5'(rd), 5'(rs), 5'(rt), lit};
    endfunction

    function automatic void emit(opcodeT op, int rd, int rs, int rt, logic [11:0] lit);
        prog.push_back(encode(op, rd, rs, rt, lit));
    endfunction

    function automatic void expectStore(logic [63:0] addr, logic [63:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endfunction

    function automatic void startProgram();
        prog.delete();
        expAddr.delete();
        expData.delete();
    endfunction

    // r10 = 0x2000 + offset, r1 = 1, r2 = 13
    function automatic void setupTarget(logic [11:0] offset);
        emit(opAddi, 1, 0, 0, 12'd1);
        emit(opAddi, 2, 0, 0, 12'd13);
        emit(opShl, 10, 1, 2, 12'd0);
        emit(opAddi, 10, 0, 0, offset);
    endfunction

    task automatic resetAndLoad();
        for (int i = 0; i < resetCycles; i++) begin
            @(posedge clk);
            reset <= 1'b1;
            if (i < prog.size()) begin
                loadStrobe <= 1'b1;
                loadAddress <= programBase + 64'(4 * i);
                loadWord <= prog[i];
            end else begin
                loadStrobe <= 1'b0;
            end
        end
        @(posedge clk);
        loadStrobe <= 1'b0;
        reset <= 1'b0;
    endtask

    task automatic runProgram(input string name);
        logic [63:0] gotAddr [$];
        logic [63:0] gotData [$];
        int cycles;
        int errorsBefore;
        errorsBefore = errors;
        resetAndLoad();
        cycles = 0;
        while (!hlt && cycles < runLimit) begin
            @(negedge clk);
            if (storeStrobe) begin
                gotAddr.push_back(storeAddress);
                gotData.push_back(storeData);
            end
            cycles++;
        end
        if (!hlt) begin
            $display("%s: timed out after %0d cycles waiting for hlt", name, runLimit);
            errors++;
        end else begin
            // Nothing may happen once halted
            for (int i = 0; i < watchCycles; i++) begin
                @(negedge clk);
                if (!hlt || storeStrobe) begin
                    $display("MISMATCH at %0t: %s hlt=%b storeStrobe=%b after halt",
                             $time, name, hlt, storeStrobe);
                    errors++;
                end
            end
        end
        if (gotAddr.size() != expAddr.size()) begin
            $display("MISMATCH at %0t: %s reported %0d stores, expected %0d",
                     $time, name, gotAddr.size(), expAddr.size());
            errors++;
        end
        for (int i = 0; i < gotAddr.size() && i < expAddr.size(); i++) begin
            if (gotAddr[i] != expAddr[i] || gotData[i] != expData[i]) begin
                $display("MISMATCH at %0t: %s store %0d got %h <= %h, expected %h <= %h",
                         $time, name, i, gotAddr[i], gotData[i], expAddr[i], expData[i]);
                errors++;
            end
        end
        testsRun++;
        if (errors != errorsBefore) begin
            testsFailed++;
        end
        $display("%s: %s", name, (errors == errorsBefore) ? "ok" : "failed");
    endtask

    function automatic void aluStep(opcodeT op, logic [11:0] addr, logic [63:0] expected);
        emit(op, 3, 1, 2, 12'd0);
        emit(opSt, 0, 3, 0, addr);
        expectStore(64'(addr), expected);
    endfunction

    task automatic registerAluTest();
        logic [63:0] a;
        logic [63:0] b;
        a = 64'($urandom_range(4095, 1));
        b = 64'($urandom_range(4095, 1));
        startProgram();
        emit(opAddi, 1, 0, 0, a[11:0]);
        emit(opAddi, 2, 0, 0, b[11:0]);
        aluStep(opAdd, 12'h100, a + b);
        aluStep(opSub, 12'h108, a - b);
        aluStep(opMul, 12'h110, a * b);
        aluStep(opAnd, 12'h118, a & b);
        aluStep(opOr, 12'h120, a | b);
        emit(opHalt, 0, 0, 0, 12'd0);
        runProgram("register alu arithmetic");
        // Small nonzero shift and bit 11 of a set so shifted values stay nonzero
        b = 64'($urandom_range(11, 1));
        a = a | 64'h800;
        startProgram();
        emit(opAddi, 1, 0, 0, a[11:0]);
        emit(opAddi, 2, 0, 0, b[11:0]);
        aluStep(opXor, 12'h128, a ^ b);
        aluStep(opNot, 12'h130, ~a);
        aluStep(opShr, 12'h138, a >> b);
        aluStep(opShl, 12'h140, a << b);
        emit(opHalt, 0, 0, 0, 12'd0);
        runProgram("register alu logic and shifts");
    endtask

    task automatic immediateTest();
        logic [11:0] x;
        logic [11:0] y;
        logic [11:0] z;
        logic [63:0] v;
        // y above x so subi wraps and merge has upper bits to keep
        x = 12'($urandom) & 12'h7FF;
        y = 12'($urandom) | 12'h800;
        z = 12'($urandom);
        startProgram();
        emit(opAddi, 1, 0, 0, x);
        emit(opSt, 0, 1, 0, 12'h180);
        emit(opSubi, 1, 0, 0, y);
        emit(opSt, 0, 1, 0, 12'h188);
        emit(opMerge, 1, 0, 0, z);
        emit(opSt, 0, 1, 0, 12'h190);
        emit(opHalt, 0, 0, 0, 12'd0);
        v = 64'(x);
        expectStore(64'h180, v);
        v = v - 64'(y);
        expectStore(64'h188, v);
        v = {v[63:12], z};
        expectStore(64'h190, v);
        runProgram("immediate forms");
    endtask

    task automatic loadStoreRoundTrip();
        logic [11:0] hi;
        logic [11:0] lo;
        int shift;
        logic [63:0] value;
        hi = 12'($urandom_range(4095, 1));
        lo = 12'($urandom);
        shift = $urandom_range(40, 8);
        value = (64'(hi) << shift) + 64'(lo);
        startProgram();
        emit(opAddi, 1, 0, 0, hi);
        emit(opAddi, 2, 0, 0, 12'(shift));
        emit(opShl, 1, 1, 2, 12'd0);
        emit(opAddi, 1, 0, 0, lo);
        emit(opAddi, 5, 0, 0, 12'h200);
        emit(opSt, 5, 1, 0, 12'h018);
        emit(opLd, 4, 5, 0, 12'h018);
        emit(opSt, 0, 4, 0, 12'h1C0);
        emit(opHalt, 0, 0, 0, 12'd0);
        expectStore(64'h218, value);
        expectStore(64'h1C0, value);
        runProgram("load and store round trip");
    endtask

    task automatic branchPaths();
        // Each of brnz and brgt runs not taken then taken
        // Wrong paths store to 0x308 or halt early
        startProgram();
        setupTarget(12'h020);
        emit(opBrnz, 10, 0, 0, 12'd0);
        emit(opSt, 0, 1, 0, 12'h300);
        emit(opBrnz, 10, 1, 0, 12'd0);
        emit(opSt, 0, 2, 0, 12'h308);
        emit(opSt, 0, 2, 0, 12'h310);
        emit(opBrgt, 10, 1, 2, 12'd0);
        emit(opSt, 0, 10, 0, 12'h318);
        emit(opAddi, 10, 0, 0, 12'h018);
        emit(opBrgt, 10, 2, 1, 12'd0);
        emit(opHalt, 0, 0, 0, 12'd0);
        emit(opSt, 0, 10, 0, 12'h320);
        emit(opHalt, 0, 0, 0, 12'd0);
        expectStore(64'h300, 64'd1);
        expectStore(64'h310, 64'd13);
        expectStore(64'h318, 64'h2020);
        expectStore(64'h320, 64'h2038);
        runProgram("brnz and brgt");

        startProgram();
        setupTarget(12'h01C);
        emit(opJmp, 10, 0, 0, 12'd0);
        emit(opSt, 0, 1, 0, 12'h330);
        emit(opHalt, 0, 0, 0, 12'd0);
        emit(opSt, 0, 2, 0, 12'h338);
        emit(opAddi, 3, 0, 0, 12'd12);
        emit(opBr, 0, 0, 3, 12'd0);
        emit(opSt, 0, 1, 0, 12'h340);
        emit(opHalt, 0, 0, 0, 12'd0);
        emit(opSt, 0, 10, 0, 12'h348);
        emit(opHalt, 0, 0, 0, 12'd0);
        expectStore(64'h338, 64'd13);
        expectStore(64'h348, 64'h201C);
        runProgram("jmp and br");
    endtask

    task automatic callAndReturn();
        startProgram();
        setupTarget(12'h01C);
        emit(opCall, 10, 0, 0, 12'd0);
        emit(opSt, 0, 2, 0, 12'h350);
        emit(opHalt, 0, 0, 0, 12'd0);
        emit(opSt, 0, 10, 0, 12'h358);
        emit(opRet, 0, 0, 0, 12'd0);
        // Return slot sits just below the top of memory
        expectStore((64'd1 << tbMemAddrBits) - 64'd8, programBase + 64'h14);
        expectStore(64'h358, 64'h201C);
        expectStore(64'h350, 64'd13);
        runProgram("call and return");
    endtask

    task automatic haltAndRestart();
        logic [11:0] v;
        v = 12'($urandom);
        startProgram();
        emit(opAddi, 1, 0, 0, v);
        emit(opSt, 0, 1, 0, 12'h360);
        emit(opHalt, 0, 0, 0, 12'd0);
        emit(opSt, 0, 1, 0, 12'h368);
        expectStore(64'h360, 64'(v));
        runProgram("halt");
        // Program stays in memory so only reset is repeated
        prog.delete();
        runProgram("restart after halt");
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        loadStrobe = 1'b0;
        loadAddress = '0;
        loadWord = '0;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        void'($urandom(32'hc3c0_c925));
        registerAluTest();
        immediateTest();
        loadStoreRoundTrip();
        branchPaths();
        callAndReturn();
        haltAndRestart();
        assertFailures = uut.control.checks.failures;
        $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 testsRun, testsFailed, errors, assertFailures);
        if (errors == 0 && assertFailures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sources.f */
tinkerCfgPkg.sv
tinkerIsaPkg.sv
fetchUnit.sv
tinkerMemory.sv
sequencer.sv
registerFile.sv
executeUnit.sv
tinkerCore.sv
tinkerCore_assert.sv
tinkerCoreTb.sv
